/* sim/rr_cases.txt */
# W port addr data | R random ready 1/0 | F flush pulse
# I lane 0 then lane 1: valid opc pc imm prs1 re1 prs2 re2 prd prd_we rob_id
W 0 01 11111111
W 1 02 22222222
I 1 10 1000 5 00 0 00 0 03 1 0 1 11 1004 6 00 0 00 0 04 1 1
I 1 12 1008 0 01 1 02 1 05 1 2 1 13 100c 7 02 1 01 1 06 1 3
I 1 14 1010 8 01 1 02 0 07 0 4 0 15 1014 9 01 1 02 1 08 1 5
W 0 09 aaaa0001
W 1 0a bbbb0002
I 1 16 1018 a 09 1 0a 1 0b 1 6 1 17 101c b 0a 1 09 1 0c 1 7
W 0 0d 12345678
W 1 0d 87654321
I 1 18 1020 c 0d 1 01 1 0e 1 8 1 19 1024 d 02 1 0d 1 0f 1 9
I 1 1a 1028 e 3f 1 3f 0 10 0 a 1 1b 102c f 00 1 00 1 11 1 b
F
I 1 1c 1030 10 0d 1 09 1 12 1 c 1 1d 1034 11 0a 1 01 1 13 1 d
R 1
W 0 20 cafe0020
I 1 20 1038 12 20 1 0d 1 14 1 e 1 21 103c 13 09 1 20 1 15 1 f
I 1 22 1040 14 01 1 02 1 16 0 0 1 23 1044 15 0a 0 0a 1 17 1 1
W 1 21 beef0021
W 0 22 f00d0022
I 1 24 1048 16 21 1 22 1 18 1 2 0 25 104c 17 21 1 22 1 19 0 3
I 1 26 1050 18 22 1 21 1 1a 1 4 1 27 1054 19 20 1 01 0 1b 1 5
I 0 28 1058 1a 01 1 02 1 1c 1 6 1 29 105c 1b 3f 1 0d 1 1d 1 7
W 0 23 0badf00d
I 1 2a 1060 1c 23 1 23 1 1e 1 8 1 2b 1064 1d 22 1 20 1 1f 1 9
I 1 2c 1068 1e 0a 1 09 1 20 1 a 1 2d 106c 1f 02 1 01 1 21 1 b
F
I 1 2e 1070 20 21 1 23 1 22 1 c 1 2f 1074 21 0d 1 20 1 23 1 d
R 0
I 1 30 1078 22 01 1 02 1 24 1 e 1 31 107c 23 09 1 0a 1 25 1 f

/* sim/tb_ncpu_rr.sv */
////////////////////
// Testbench for the register-read stage, with model register file
////////////////////
`timescale 1ns/1ps
`include "ncpu_rr_cfg.svh"

module tb_ncpu_rr
   import ncpu_rr_pkg::*;
();

   logic                   clk;
   logic                   arst_n;
   logic                   flush;
   rr_group_t              in_group;
   logic                   in_valid;
   logic                   in_ready;
   ex_group_t              ex_group;
   logic                   ex_valid;
   logic                   ex_ready;
   prf_wb_t [`NCPU_IW-1:0] wb;

   logic [`NCPU_DW-1:0]    model_rf [1 << `NCPU_PRF_AW];
   ex_group_t              exp_q [$];     // Accepted groups not yet out
   string                  cases [$];
   logic                   model_valid;   // Predicted stage occupancy
   logic                   random_mode;
   logic [31:0]            rng;
   int                     errors = 0;
   int                     cycles = 0;
   int                     cycle_limit = 0;
   int                     issued = 0;
   int                     delivered = 0;
   int                     dropped = 0;

   ncpu_rr_top dut0
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .flush    (flush),
      .in_group (in_group),
      .in_valid (in_valid),
      .in_ready (in_ready),
      .ex_group (ex_group),
      .ex_valid (ex_valid),
      .ex_ready (ex_ready),
      .wb       (wb)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x ^ (x << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Expected output group, operands from the model at the accept edge
   function automatic ex_group_t expect_group(input rr_group_t g);
      ex_group_t e;
      for (int i = 0; i < `NCPU_IW; i++)
      begin
         e[i].lane_valid = g[i].lane_valid;
         e[i].opc        = g[i].opc;
         e[i].pc         = g[i].pc;
         e[i].imm        = g[i].imm;
         e[i].prd        = g[i].prd;
         e[i].prd_we     = g[i].prd_we;
         e[i].rob_id     = g[i].rob_id;
         e[i].operand1   = (g[i].lane_valid && g[i].prs1_re) ? model_rf[g[i].prs1] : '0;
         e[i].operand2   = (g[i].lane_valid && g[i].prs2_re) ? model_rf[g[i].prs2] : '0;
      end
      return e;
   endfunction

   task automatic check_field(input string name, input int lane,
                              input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         errors++;
         $display("mismatch ex_group[%0d].%s expected %h actual %h", lane, name, exp, act);
      end
   endtask

   task automatic compare_group(input ex_group_t e);
      for (int i = 0; i < `NCPU_IW; i++)
      begin
         check_field("lane_valid", i, e[i].lane_valid, ex_group[i].lane_valid);
         check_field("opc", i, e[i].opc, ex_group[i].opc);
         check_field("pc", i, e[i].pc, ex_group[i].pc);
         check_field("imm", i, e[i].imm, ex_group[i].imm);
         check_field("prd", i, e[i].prd, ex_group[i].prd);
         check_field("prd_we", i, e[i].prd_we, ex_group[i].prd_we);
         check_field("rob_id", i, e[i].rob_id, ex_group[i].rob_id);
         check_field("operand1", i, e[i].operand1, ex_group[i].operand1);
         check_field("operand2", i, e[i].operand2, ex_group[i].operand2);
      end
   endtask

   task automatic report_counts();
      $display("Errors %0d, issued %0d, delivered %0d, flushed %0d",
               errors, issued, delivered, dropped);
   endtask

   // One clock cycle, entered and left just after a falling edge
   task automatic run_cycle();
      logic exp_ready;
      logic accept;
      if (flush)
      begin
         ex_ready = 1'b0;   // Held group must not drain on the flush edge
      end
      else if (random_mode)
      begin
         rng = xorshift32(rng);
         ex_ready = rng[3];
      end
      else
      begin
         ex_ready = 1'b1;
      end
      #1;
      exp_ready = ~model_valid | ex_ready;
      accept = in_valid & exp_ready & ~flush;
      if (in_ready !== exp_ready)
      begin
         errors++;
         $display("mismatch in_ready expected %h actual %h", exp_ready, in_ready);
      end
      if (ex_valid !== model_valid)
      begin
         errors++;
         $display("mismatch ex_valid expected %h actual %h", model_valid, ex_valid);
      end
      if (ex_valid === 1'b1 && ex_ready && !flush)
      begin
         delivered++;   // Transfer seen at the DUT boundary
      end
      if (model_valid)
      begin
         compare_group(exp_q[0]);   // Also every stalled cycle
         if (flush)
         begin
            exp_q.delete(0);
            dropped++;
         end
         else if (ex_ready)
         begin
            exp_q.delete(0);
         end
      end
      @(posedge clk);
      for (int w = 0; w < `NCPU_IW; w++)
      begin
         if (wb[w].we)
         begin
            model_rf[wb[w].addr] = wb[w].data;   // Later port overwrites
         end
      end
      if (accept)
      begin
         exp_q.push_back(expect_group(in_group));   // After the writes, so write-first
         issued++;
      end
      model_valid = flush ? 1'b0 : (accept ? 1'b1 : (model_valid & ~ex_ready));
      @(negedge clk);
      wb = '0;
      flush = 1'b0;
      if (accept)
      begin
         in_valid = 1'b0;
      end
   endtask

   initial
   begin
      wait (cycle_limit > 0);
      wait (cycles >= cycle_limit);
      errors++;
      $display("Timeout after %0d cycles, groups still pending", cycles);
      report_counts();
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      int                        fd;
      int                        n;
      int                        port;
      int                        mode;
      string                     line;
      logic [31:0]               v [22];
      logic [`NCPU_PRF_AW-1:0]   addr;
      logic [`NCPU_DW-1:0]       data;
      rr_group_t                 g;

      clk = 1'b0;
      arst_n = 1'b0;
      flush = 1'b0;
      in_group = '0;
      in_valid = 1'b0;
      ex_ready = 1'b0;
      wb = '0;
      model_valid = 1'b0;
      random_mode = 1'b0;
      rng = 32'd46;
      for (int r = 0; r < (1 << `NCPU_PRF_AW); r++)
      begin
         model_rf[r] = '0;   // Register file clears at reset
      end

      fd = $fopen("sim/rr_cases.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("Could not open the case file sim/rr_cases.txt");
      end
      else
      begin
         while ($fgets(line, fd) > 0)
         begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               cases.push_back(line);
            end
         end
         $fclose(fd);
      end
      cycle_limit = 20 * cases.size() + 100;

      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      repeat (2) run_cycle();   // Nothing may come out before the first issue

      foreach (cases[c])
      begin
         line = cases[c];
         case (line.getc(0))
            "W":
            begin
               n = $sscanf(line, "W %d %h %h", port, addr, data);
               if (n != 3 || port < 0 || port >= `NCPU_IW)
               begin
                  errors++;
                  $display("Unreadable writeback line: %0s", line);
               end
               else
               begin
                  wb[port].we   = 1'b1;   // Applied on the next edge
                  wb[port].addr = addr;
                  wb[port].data = data;
               end
            end
            "I":
            begin
               n = $sscanf(line,
                  "I %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                  v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20],
                  v[21]);
               if (n != 22)
               begin
                  errors++;
                  $display("Unreadable issue line: %0s", line);
               end
               else
               begin
                  for (int l = 0; l < `NCPU_IW; l++)
                  begin
                     g[l].lane_valid = v[11*l];
                     g[l].opc        = v[11*l+1];
                     g[l].pc         = v[11*l+2];
                     g[l].imm        = v[11*l+3];
                     g[l].prs1       = v[11*l+4];
                     g[l].prs1_re    = v[11*l+5];
                     g[l].prs2       = v[11*l+6];
                     g[l].prs2_re    = v[11*l+7];
                     g[l].prd        = v[11*l+8];
                     g[l].prd_we     = v[11*l+9];
                     g[l].rob_id     = v[11*l+10];
                  end
                  in_group = g;
                  in_valid = 1'b1;
                  while (in_valid)
                  begin
                     run_cycle();   // Until the stage takes it
                  end
               end
            end
            "R":
            begin
               n = $sscanf(line, "R %d", mode);
               random_mode = (n == 1) && (mode != 0);
            end
            "F":
            begin
               flush = 1'b1;
               run_cycle();
            end
            default:
            begin
               errors++;
               $display("Unknown command in case file: %0s", line);
            end
         endcase
      end

      while (exp_q.size() > 0)
      begin
         run_cycle();
      end
      repeat (3) run_cycle();   // No stray groups afterwards
      if (delivered != issued - dropped)
      begin
         errors++;
         $display("Delivered groups do not match issued minus flushed groups");
      end
      report_counts();
      if (errors == 0)
      begin
         $display("Finished with no errors");
      end
      else
      begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* src.f */
+incdir+src
src/ncpu_rr_pkg.sv
src/hds_buf.sv
src/prf.sv
src/ro.sv
src/ncpu_rr_top.sv
sim/tb_ncpu_rr.sv

/* src/hds_buf.sv */
////////////////////
// One-entry valid/ready pipeline buffer with flush
////////////////////
`timescale 1ns/1ps

module hds_buf
(
   input  logic   clk,
   input  logic   arst_n,
   input  logic   flush,
   input  logic   a_valid,
   output logic   a_ready,
   output logic   b_valid,
   input  logic   b_ready,
   output logic   p_ce
);

   logic valid_q;   // Stage holds a group

   // Room when empty or when the held group drains this cycle
   assign a_ready = ~valid_q | b_ready;

   // Load enable for the stage payload registers
   // A flush edge takes nothing in
   assign p_ce = a_valid & a_ready & ~flush;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (~arst_n)
      begin
         valid_q <= 1'b0;
      end
      else if (flush)
      begin
         valid_q <= 1'b0;   // Drop whatever is held
      end
      else if (p_ce)
      begin
         valid_q <= 1'b1;
      end
      else if (b_ready)
      begin
         valid_q <= 1'b0;   // Drained, nothing new behind it
      end
   end

   assign b_valid = valid_q;

endmodule

/* src/ncpu_rr_cfg.svh */
////////////////////
// Sizing macros for the register-read stage and register file
////////////////////
`ifndef NCPU_RR_CFG_SVH
`define NCPU_RR_CFG_SVH

// Issue lanes per group
`define NCPU_IW 2

`define NCPU_DW 32         // Data width
`define NCPU_PRF_AW 6      // 64 physical registers
`define NCPU_PC_W 32       // PC width

// Reorder buffer id width
`define NCPU_ROB_AW 4

// Merged opcode word per lane
`define NCPU_UOP_W 8

`endif

/* src/ncpu_rr_pkg.sv */
////////////////////
// Issue, execute and writeback types
////////////////////
`include "ncpu_rr_cfg.svh"

package ncpu_rr_pkg;

   // One issued lane as it leaves the issue queue
   typedef struct packed {
      logic                      lane_valid;
      logic [`NCPU_UOP_W-1:0]    opc;
      logic [`NCPU_PC_W-1:0]     pc;
      logic [`NCPU_DW-1:0]       imm;
      logic [`NCPU_PRF_AW-1:0]   prs1;
      logic                      prs1_re;
      logic [`NCPU_PRF_AW-1:0]   prs2;
      logic                      prs2_re;
      logic [`NCPU_PRF_AW-1:0]   prd;
      logic                      prd_we;
      logic [`NCPU_ROB_AW-1:0]   rob_id;
   } rr_uop_t;

   typedef rr_uop_t [`NCPU_IW-1:0] rr_group_t;

   // Lane toward execution, operands filled in
   typedef struct packed {
      logic                      lane_valid;
      logic [`NCPU_UOP_W-1:0]    opc;
      logic [`NCPU_PC_W-1:0]     pc;
      logic [`NCPU_DW-1:0]       imm;
      logic [`NCPU_PRF_AW-1:0]   prd;
      logic                      prd_we;
      logic [`NCPU_ROB_AW-1:0]   rob_id;
      logic [`NCPU_DW-1:0]       operand1;
      logic [`NCPU_DW-1:0]       operand2;
   } ex_uop_t;

   typedef ex_uop_t [`NCPU_IW-1:0] ex_group_t;

   typedef struct packed {
      logic                      we;
      logic [`NCPU_PRF_AW-1:0]   addr;
      logic [`NCPU_DW-1:0]       data;
   } prf_wb_t;

   typedef struct packed {
      logic                      re;
      logic [`NCPU_PRF_AW-1:0]   addr;
   } prf_rd_t;

endpackage

/* src/ncpu_rr_top.sv */
////////////////////
// Register-read stage with its register file
////////////////////
`timescale 1ns/1ps
`include "ncpu_rr_cfg.svh"

module ncpu_rr_top
   import ncpu_rr_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     flush,
   input  rr_group_t                in_group,
   input  logic                     in_valid,
   output logic                     in_ready,
   output ex_group_t                ex_group,
   output logic                     ex_valid,
   input  logic                     ex_ready,
   input  prf_wb_t [`NCPU_IW-1:0]   wb
);

   prf_rd_t [2*`NCPU_IW-1:0]              rd_port;   // Two per lane
   logic [2*`NCPU_IW-1:0][`NCPU_DW-1:0]   rd_data;

   ro u_ro
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .in_group   (in_group),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .rd_port    (rd_port),
      .rd_data    (rd_data),
      .ex_group   (ex_group),
      .ex_valid   (ex_valid),
      .ex_ready   (ex_ready)
   );

   prf u_prf
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .rd_port    (rd_port),
      .rd_data    (rd_data),
      .wb         (wb)
   );

endmodule

/* src/prf.sv */
////////////////////
// Physical register file with registered read ports
////////////////////
`timescale 1ns/1ps
`include "ncpu_rr_cfg.svh"

module prf
   import ncpu_rr_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  prf_rd_t [2*`NCPU_IW-1:0]             rd_port,
   output logic [2*`NCPU_IW-1:0][`NCPU_DW-1:0]  rd_data,
   input  prf_wb_t [`NCPU_IW-1:0]               wb
);

   localparam int NREG = 1 << `NCPU_PRF_AW;
   localparam int NRP  = 2 * `NCPU_IW;   // Two sources per lane

   logic [`NCPU_DW-1:0]             regs [NREG];
   logic [NRP-1:0][`NCPU_DW-1:0]    rd_fwd;   // Array word or bypassed writeback

   // Storage update
   // The loop order lets the higher-numbered writeback port win on a collision
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (~arst_n)
      begin
         for (int r = 0; r < NREG; r++)
         begin
            regs[r] <= '0;
         end
      end
      else
      begin
         for (int w = 0; w < `NCPU_IW; w++)
         begin
            if (wb[w].we)
            begin
               regs[wb[w].addr] <= wb[w].data;
            end
         end
      end
   end

   // Write-first bypass, same priority as the storage update
   always_comb
   begin
      for (int p = 0; p < NRP; p++)
      begin
         rd_fwd[p] = regs[rd_port[p].addr];
         for (int w = 0; w < `NCPU_IW; w++)
         begin
            if (wb[w].we && (wb[w].addr == rd_port[p].addr))
            begin
               rd_fwd[p] = wb[w].data;
            end
         end
      end
   end

   // Read registers hold while re is low so a stalled stage keeps its operands
   always_ff @(posedge clk)
   begin
      for (int p = 0; p < NRP; p++)
      begin
         if (rd_port[p].re)
         begin
            rd_data[p] <= rd_fwd[p];
         end
      end
   end

endmodule

/* src/ro.sv */
////////////////////
// Register-read stage between issue and execution
////////////////////
`timescale 1ns/1ps
`include "ncpu_rr_cfg.svh"

module ro
   import ncpu_rr_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 arst_n,
   input  logic                                 flush,
   input  rr_group_t                            in_group,
   input  logic                                 in_valid,
   output logic                                 in_ready,
   output prf_rd_t [2*`NCPU_IW-1:0]             rd_port,
   input  logic [2*`NCPU_IW-1:0][`NCPU_DW-1:0]  rd_data,
   output ex_group_t                            ex_group,
   output logic                                 ex_valid,
   input  logic                                 ex_ready
);

   // Fields held in the stage, operands come later from the register file
   typedef struct packed {
      logic                      lane_valid;
      logic [`NCPU_UOP_W-1:0]    opc;
      logic [`NCPU_PC_W-1:0]     pc;
      logic [`NCPU_DW-1:0]       imm;
      logic [`NCPU_PRF_AW-1:0]   prd;
      logic                      prd_we;
      logic [`NCPU_ROB_AW-1:0]   rob_id;
      logic                      prs1_re;
      logic                      prs2_re;
   } ro_hold_t;

   logic                         p_ce;     // Stage load enable
   ro_hold_t [`NCPU_IW-1:0]      hold_q;

   hds_buf u_buf
   (
      .clk     (clk),
      .arst_n  (arst_n),
      .flush   (flush),
      .a_valid (in_valid),
      .a_ready (in_ready),
      .b_valid (ex_valid),
      .b_ready (ex_ready),
      .p_ce    (p_ce)
   );

   // Reads go out in the same cycle the group is accepted
   always_comb
   begin
      for (int i = 0; i < `NCPU_IW; i++)
      begin
         rd_port[2*i].re     = p_ce & in_group[i].lane_valid & in_group[i].prs1_re;
         rd_port[2*i].addr   = in_group[i].prs1;
         rd_port[2*i+1].re   = p_ce & in_group[i].lane_valid & in_group[i].prs2_re;
         rd_port[2*i+1].addr = in_group[i].prs2;
      end
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         for (int i = 0; i < `NCPU_IW; i++)
         begin
            hold_q[i].lane_valid <= in_group[i].lane_valid;
            hold_q[i].opc        <= in_group[i].opc;
            hold_q[i].pc         <= in_group[i].pc;
            hold_q[i].imm        <= in_group[i].imm;
            hold_q[i].prd        <= in_group[i].prd;
            hold_q[i].prd_we     <= in_group[i].prd_we;
            hold_q[i].rob_id     <= in_group[i].rob_id;
            hold_q[i].prs1_re    <= in_group[i].prs1_re;
            hold_q[i].prs2_re    <= in_group[i].prs2_re;
         end
      end
   end

   // Unread sources and empty lanes give zero operands
   always_comb
   begin
      for (int i = 0; i < `NCPU_IW; i++)
      begin
         ex_group[i].lane_valid = hold_q[i].lane_valid;
         ex_group[i].opc        = hold_q[i].opc;
         ex_group[i].pc         = hold_q[i].pc;
         ex_group[i].imm        = hold_q[i].imm;
         ex_group[i].prd        = hold_q[i].prd;
         ex_group[i].prd_we     = hold_q[i].prd_we;
         ex_group[i].rob_id     = hold_q[i].rob_id;
         ex_group[i].operand1   = (hold_q[i].lane_valid & hold_q[i].prs1_re) ?
                                  rd_data[2*i] : '0;
         ex_group[i].operand2   = (hold_q[i].lane_valid & hold_q[i].prs2_re) ?
                                  rd_data[2*i+1] : '0;
      end
   end

endmodule
